/* include/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address and word widths
`define CACHE_PLEN        34
`define CACHE_XLEN        32

// geometry, 2 ways x 16 sets x 128 bit lines
`define CACHE_WAYS        2
`define CACHE_SETS        16
`define CACHE_BLK_BITS    128

// address split
`define CACHE_IDX_BITS    4    // log2 of sets
`define CACHE_OFFS_BITS   4    // byte offset in line
`define CACHE_WOFFS_BITS  2    // word offset in line

// whatever is left above index and offset
`define CACHE_TAG_BITS    (`CACHE_PLEN - `CACHE_IDX_BITS - `CACHE_OFFS_BITS)

`endif

/* logic/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

  // address fields
  typedef logic [`CACHE_IDX_BITS-1:0]     idx_t;
  typedef logic [`CACHE_TAG_BITS-1:0]     tag_t;
  typedef logic [`CACHE_WOFFS_BITS-1:0]   woffs_t;

  // payload
  typedef logic [`CACHE_BLK_BITS-1:0]     line_t;
  typedef logic [`CACHE_BLK_BITS/8-1:0]   line_be_t;
  typedef logic [`CACHE_XLEN-1:0]         word_t;
  typedef logic [`CACHE_XLEN/8-1:0]       word_be_t;

  typedef logic [`CACHE_WAYS-1:0]         way_t;     // one-hot

  // what the memories do this cycle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'b00,
    OP_READ  = 2'b01,
    OP_FILL  = 2'b10,
    OP_WRITE = 2'b11
  } mem_op_e;

endpackage

/* logic/cache_ram_1rw.sv */
`timescale 1ns/1ns

module cache_ram_1rw #(
  parameter int ABITS = 4,
  parameter int DBITS = 32
)
(
  input  logic                   clk_i,
  input  logic [ABITS-1:0]       addr_i,
  input  logic                   we_i,
  input  logic [(DBITS+7)/8-1:0] be_i,
  input  logic [DBITS-1:0]       din_i,
  output logic [DBITS-1:0]       dout_o
);

  logic [DBITS-1:0] mem [2**ABITS];   // contents qualified by valid flags

  // byte enable per bit, last byte may be partial
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int b = 0; b < DBITS; b++)
      begin
        if (be_i[b/8]) mem[addr_i][b] <= din_i[b];
      end
    end
  end

  // registered read, old data on a write cycle
  always_ff @(posedge clk_i)
  begin
    dout_o <= mem[addr_i];
  end

endmodule

/* logic/cache_access_ctl.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_access_ctl
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rreq_i,
  input  cache_pkg::idx_t     rd_idx_i,
  input  cache_pkg::tag_t     rd_tag_i,
  input  cache_pkg::way_t     victim_way_i,
  input  logic                fill_i,
  input  cache_pkg::idx_t     fill_idx_i,
  input  cache_pkg::tag_t     fill_tag_i,
  input  cache_pkg::way_t     fill_way_i,
  input  cache_pkg::line_t    fill_line_i,
  input  logic                fill_dirty_i,
  input  logic                wb_we_i,
  input  cache_pkg::idx_t     wb_idx_i,
  input  cache_pkg::woffs_t   wb_woffs_i,
  input  cache_pkg::word_be_t wb_be_i,
  input  cache_pkg::word_t    wb_data_i,
  input  cache_pkg::way_t     wb_way_i,
  input  logic                inval_all_i,
  output cache_pkg::idx_t     idx_o,
  output cache_pkg::way_t     tag_we_o,
  output cache_pkg::way_t     dirty_we_o,
  output logic                dirty_val_o,
  output cache_pkg::way_t     dat_we_o,
  output cache_pkg::line_be_t dat_be_o,
  output cache_pkg::line_t    dat_line_o,
  output cache_pkg::tag_t     tag_wr_o,
  output logic                inval_all_o,
  output logic                rd_valid_o,
  output cache_pkg::tag_t     rd_tag_o,
  output cache_pkg::way_t     rd_victim_o
);

  import cache_pkg::*;

  mem_op_e  op;
  line_be_t wr_be;    // word enables moved to word slot
  line_t    wr_line;  // word copied to every slot

  //////////////////////////////////////////////////////////////
  // decode, fill beats write beats read
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    if (fill_i)       op = OP_FILL;
    else if (wb_we_i) op = OP_WRITE;
    else if (rreq_i)  op = OP_READ;
    else              op = OP_IDLE;
  end

  assign wr_be   = line_be_t'(wb_be_i) << (int'(wb_woffs_i) * (`CACHE_XLEN / 8));
  assign wr_line = {(`CACHE_BLK_BITS / `CACHE_XLEN){wb_data_i}};

  always_comb
  begin
    idx_o       = rd_idx_i;     // idle and read
    tag_we_o    = '0;
    dirty_we_o  = '0;
    dirty_val_o = 1'b0;
    dat_we_o    = '0;
    dat_be_o    = '1;           // full line unless word write
    dat_line_o  = fill_line_i;
    case (op)
      OP_FILL:
      begin
        idx_o       = fill_idx_i;
        tag_we_o    = fill_way_i;   // also sets valid
        dirty_we_o  = fill_way_i;
        dirty_val_o = fill_dirty_i;
        dat_we_o    = fill_way_i;
      end
      OP_WRITE:
      begin
        idx_o       = wb_idx_i;
        dirty_we_o  = wb_way_i;
        dirty_val_o = 1'b1;         // write buffer always dirties
        dat_we_o    = wb_way_i;
        dat_be_o    = wr_be;
        dat_line_o  = wr_line;
      end
      default:
      begin
      end
    endcase
  end

  assign tag_wr_o    = fill_tag_i;
  assign inval_all_o = inval_all_i;

  //////////////////////////////////////////////////////////////
  // read context, same delay as the rams
  //////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) rd_valid_o <= 1'b0;
    else         rd_valid_o <= (op == OP_READ);
  end

  always_ff @(posedge clk_i)
  begin
    if (op == OP_READ)
    begin
      rd_tag_o    <= rd_tag_i;
      rd_victim_o <= victim_way_i;
    end
  end

endmodule

/* logic/cache_tag_store.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tag_store
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  cache_pkg::idx_t   idx_i,
  input  cache_pkg::way_t   tag_we_i,
  input  cache_pkg::way_t   dirty_we_i,
  input  logic              dirty_val_i,
  input  cache_pkg::tag_t   tag_wr_i,
  input  logic              inval_all_i,
  output cache_pkg::tag_t   tag_q_o [`CACHE_WAYS],
  output cache_pkg::way_t   valid_q_o,
  output cache_pkg::way_t   dirty_q_o
);

  import cache_pkg::*;

  // per way flag vectors, one bit per set
  logic [`CACHE_SETS-1:0] valid_arr [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0] dirty_arr [`CACHE_WAYS];

  for (genvar w = 0; w < `CACHE_WAYS; w++)
  begin : g_way
    tag_t tag_rd;   // ram output of this way

    cache_ram_1rw #(
      .ABITS  ( `CACHE_IDX_BITS                ),
      .DBITS  ( `CACHE_TAG_BITS                )
    ) u_tag_ram (
      .clk_i  ( clk_i                          ),
      .addr_i ( idx_i                          ),
      .we_i   ( tag_we_i[w]                    ),
      .be_i   ( {(`CACHE_TAG_BITS+7)/8{1'b1}}  ),
      .din_i  ( tag_wr_i                       ),
      .dout_o ( tag_rd                         )
    );

    assign tag_q_o[w] = tag_rd;

    // valid, global invalidate first
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)          valid_arr[w]        <= '0;
      else if (inval_all_i) valid_arr[w]        <= '0;
      else if (tag_we_i[w]) valid_arr[w][idx_i] <= 1'b1;
    end

    // dirty, loaded by fill or set by word write
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)            dirty_arr[w]        <= '0;
      else if (dirty_we_i[w]) dirty_arr[w][idx_i] <= dirty_val_i;
    end

    // flag read-out lines up with ram dout
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q_o[w] <= 1'b0;
        dirty_q_o[w] <= 1'b0;
      end
      else
      begin
        valid_q_o[w] <= valid_arr[w][idx_i];
        dirty_q_o[w] <= dirty_arr[w][idx_i];
      end
    end
  end

endmodule

/* logic/cache_data_store.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_data_store
(
  input  logic                clk_i,
  input  cache_pkg::idx_t     idx_i,
  input  cache_pkg::way_t     dat_we_i,
  input  cache_pkg::line_be_t dat_be_i,
  input  cache_pkg::line_t    dat_line_i,
  output cache_pkg::line_t    line_q_o [`CACHE_WAYS]
);

  //////////////////////////////////////////////////////////////
  // one line ram per way, shared write data and enables
  //////////////////////////////////////////////////////////////
  for (genvar w = 0; w < `CACHE_WAYS; w++)
  begin : g_way
    logic [`CACHE_BLK_BITS-1:0] line_rd;

    cache_ram_1rw #(
      .ABITS  ( `CACHE_IDX_BITS ),
      .DBITS  ( `CACHE_BLK_BITS )
    ) u_dat_ram (
      .clk_i  ( clk_i           ),
      .addr_i ( idx_i           ),
      .we_i   ( dat_we_i[w]     ),   // only the target way
      .be_i   ( dat_be_i        ),
      .din_i  ( dat_line_i      ),
      .dout_o ( line_rd         )
    );

    // all ways read at the same index
    assign line_q_o[w] = line_rd;
  end

endmodule

/* logic/cache_lookup.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_lookup
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rd_valid_i,
  input  cache_pkg::tag_t   rd_tag_i,
  input  cache_pkg::way_t   rd_victim_i,
  input  cache_pkg::tag_t   tag_q_i [`CACHE_WAYS],
  input  cache_pkg::way_t   valid_q_i,
  input  cache_pkg::way_t   dirty_q_i,
  input  cache_pkg::line_t  line_q_i [`CACHE_WAYS],
  output logic              rsp_valid_o,
  output logic              hit_o,
  output cache_pkg::way_t   ways_hit_o,
  output cache_pkg::line_t  line_o,
  output cache_pkg::tag_t   evict_tag_o,
  output cache_pkg::line_t  evict_line_o,
  output logic              evict_dirty_o
);

  import cache_pkg::*;

  way_t  way_hit;
  line_t hit_line;
  line_t vic_line;
  tag_t  vic_tag;
  logic  vic_dirty;

  //////////////////////////////////////////////////////////////
  // compare and and-or muxes
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_line  = '0;
    vic_line  = '0;
    vic_tag   = '0;
    vic_dirty = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      way_hit[w] = valid_q_i[w] & (tag_q_i[w] == rd_tag_i);
      if (way_hit[w])     hit_line |= line_q_i[w];   // at most one way hits
      if (rd_victim_i[w])
      begin
        vic_line  |= line_q_i[w];
        vic_tag   |= tag_q_i[w];
        vic_dirty |= valid_q_i[w] & dirty_q_i[w];    // stale dirty ignored
      end
    end
  end

  // response strobe
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) rsp_valid_o <= 1'b0;
    else         rsp_valid_o <= rd_valid_i;
  end

  // payload holds between responses
  always_ff @(posedge clk_i)
  begin
    if (rd_valid_i)
    begin
      hit_o         <= |way_hit;
      ways_hit_o    <= way_hit;
      line_o        <= hit_line;
      evict_tag_o   <= vic_tag;
      evict_line_o  <= vic_line;
      evict_dirty_o <= vic_dirty;
    end
  end

endmodule

/* logic/cache_mem_top.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_mem_top
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rreq_i,
  input  cache_pkg::idx_t     rd_idx_i,
  input  cache_pkg::tag_t     rd_tag_i,
  input  cache_pkg::way_t     victim_way_i,
  input  logic                fill_i,
  input  cache_pkg::idx_t     fill_idx_i,
  input  cache_pkg::tag_t     fill_tag_i,
  input  cache_pkg::way_t     fill_way_i,
  input  cache_pkg::line_t    fill_line_i,
  input  logic                fill_dirty_i,
  input  logic                wb_we_i,
  input  cache_pkg::idx_t     wb_idx_i,
  input  cache_pkg::woffs_t   wb_woffs_i,
  input  cache_pkg::word_be_t wb_be_i,
  input  cache_pkg::word_t    wb_data_i,
  input  cache_pkg::way_t     wb_way_i,
  input  logic                inval_all_i,
  output logic                rsp_valid_o,
  output logic                hit_o,
  output cache_pkg::way_t     ways_hit_o,
  output cache_pkg::line_t    line_o,
  output cache_pkg::tag_t     evict_tag_o,
  output cache_pkg::line_t    evict_line_o,
  output logic                evict_dirty_o
);

  import cache_pkg::*;

  //////////////////////////////////////////////////////////////
  // stage 1 to memories
  //////////////////////////////////////////////////////////////
  idx_t     idx;
  way_t     tag_we;
  way_t     dirty_we;
  logic     dirty_val;
  way_t     dat_we;
  line_be_t dat_be;
  line_t    dat_line;
  tag_t     tag_wr;
  logic     inval_all;

  // read context, one cycle late
  logic     rd_valid;
  tag_t     rd_tag;
  way_t     rd_victim;

  // memory read data
  tag_t     tag_q  [`CACHE_WAYS];
  way_t     valid_q;
  way_t     dirty_q;
  line_t    line_q [`CACHE_WAYS];

  cache_access_ctl u_access_ctl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rreq_i       ( rreq_i       ),
    .rd_idx_i     ( rd_idx_i     ),
    .rd_tag_i     ( rd_tag_i     ),
    .victim_way_i ( victim_way_i ),
    .fill_i       ( fill_i       ),
    .fill_idx_i   ( fill_idx_i   ),
    .fill_tag_i   ( fill_tag_i   ),
    .fill_way_i   ( fill_way_i   ),
    .fill_line_i  ( fill_line_i  ),
    .fill_dirty_i ( fill_dirty_i ),
    .wb_we_i      ( wb_we_i      ),
    .wb_idx_i     ( wb_idx_i     ),
    .wb_woffs_i   ( wb_woffs_i   ),
    .wb_be_i      ( wb_be_i      ),
    .wb_data_i    ( wb_data_i    ),
    .wb_way_i     ( wb_way_i     ),
    .inval_all_i  ( inval_all_i  ),
    .idx_o        ( idx          ),
    .tag_we_o     ( tag_we       ),
    .dirty_we_o   ( dirty_we     ),
    .dirty_val_o  ( dirty_val    ),
    .dat_we_o     ( dat_we       ),
    .dat_be_o     ( dat_be       ),
    .dat_line_o   ( dat_line     ),
    .tag_wr_o     ( tag_wr       ),
    .inval_all_o  ( inval_all    ),
    .rd_valid_o   ( rd_valid     ),
    .rd_tag_o     ( rd_tag       ),
    .rd_victim_o  ( rd_victim    )
  );

  //////////////////////////////////////////////////////////////
  // stage 2, tag and data side by side
  //////////////////////////////////////////////////////////////
  cache_tag_store u_tag_store (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .idx_i       ( idx       ),
    .tag_we_i    ( tag_we    ),
    .dirty_we_i  ( dirty_we  ),
    .dirty_val_i ( dirty_val ),
    .tag_wr_i    ( tag_wr    ),
    .inval_all_i ( inval_all ),
    .tag_q_o     ( tag_q     ),
    .valid_q_o   ( valid_q   ),
    .dirty_q_o   ( dirty_q   )
  );

  cache_data_store u_data_store (
    .clk_i      ( clk_i    ),
    .idx_i      ( idx      ),
    .dat_we_i   ( dat_we   ),
    .dat_be_i   ( dat_be   ),
    .dat_line_i ( dat_line ),
    .line_q_o   ( line_q   )
  );

  // stage 3
  cache_lookup u_lookup (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .rd_valid_i    ( rd_valid      ),
    .rd_tag_i      ( rd_tag        ),
    .rd_victim_i   ( rd_victim     ),
    .tag_q_i       ( tag_q         ),
    .valid_q_i     ( valid_q       ),
    .dirty_q_i     ( dirty_q       ),
    .line_q_i      ( line_q        ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .hit_o         ( hit_o         ),
    .ways_hit_o    ( ways_hit_o    ),
    .line_o        ( line_o        ),
    .evict_tag_o   ( evict_tag_o   ),
    .evict_line_o  ( evict_line_o  ),
    .evict_dirty_o ( evict_dirty_o )
  );

endmodule

/* sim/tb_cache_mem.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module tb_cache_mem;

  import cache_pkg::*;

  // one expected read response
  typedef struct packed {
    logic  hit;
    way_t  ways;
    line_t line;
    logic  chk_evict;   // victim way valid, so tag and line are known
    tag_t  etag;
    line_t eline;
    logic  edirty;
  } rsp_t;

  logic     clk_i;
  logic     rst_ni;
  logic     rreq_i;
  idx_t     rd_idx_i;
  tag_t     rd_tag_i;
  way_t     victim_way_i;
  logic     fill_i;
  idx_t     fill_idx_i;
  tag_t     fill_tag_i;
  way_t     fill_way_i;
  line_t    fill_line_i;
  logic     fill_dirty_i;
  logic     wb_we_i;
  idx_t     wb_idx_i;
  woffs_t   wb_woffs_i;
  word_be_t wb_be_i;
  word_t    wb_data_i;
  way_t     wb_way_i;
  logic     inval_all_i;
  logic     rsp_valid_o;
  logic     hit_o;
  way_t     ways_hit_o;
  line_t    line_o;
  tag_t     evict_tag_o;
  line_t    evict_line_o;
  logic     evict_dirty_o;

  // reference model, per set and way
  logic  m_valid [`CACHE_SETS][`CACHE_WAYS];
  logic  m_dirty [`CACHE_SETS][`CACHE_WAYS];
  tag_t  m_tag   [`CACHE_SETS][`CACHE_WAYS];
  line_t m_line  [`CACHE_SETS][`CACHE_WAYS];

  rsp_t        exp_q [$];     // reads in flight, oldest first
  logic [31:0] rng_state;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;
  int          rd_cnt;
  int          test_err0;     // error count at test start

  cache_mem_top dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  // strobe latency, response exactly 2 cycles after request
  assert property (@(posedge clk_i) disable iff (!rst_ni) rsp_valid_o == $past(rreq_i, 2))
  else
  begin
    $display("Error at %0t ns: rsp_valid_o does not follow rreq_i by 2 cycles", $time);
    err_cnt++;
  end

  task automatic compare_field(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // outputs sampled mid cycle, away from the edge
  always @(negedge clk_i)
  begin
    rsp_t e;
    if (rst_ni && rsp_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error at %0t ns: response with no read outstanding", $time);
        err_cnt++;
      end
      else
      begin
        e = exp_q.pop_front();
        chk_cnt++;
        compare_field("hit_o", 128'(hit_o), 128'(e.hit));
        compare_field("ways_hit_o", 128'(ways_hit_o), 128'(e.ways));
        compare_field("line_o", line_o, e.line);
        compare_field("evict_dirty_o", 128'(evict_dirty_o), 128'(e.edirty));
        if (e.chk_evict)
        begin
          compare_field("evict_tag_o", 128'(evict_tag_o), 128'(e.etag));
          compare_field("evict_line_o", evict_line_o, e.eline);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic line_t rand_line();
    return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
  endfunction

  task automatic idle_strobes();
    rreq_i      <= 1'b0;
    fill_i      <= 1'b0;
    wb_we_i     <= 1'b0;
    inval_all_i <= 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    idle_strobes();
  endtask

  // expectation taken from the model at issue time
  task automatic do_read(input idx_t idx, input tag_t tag, input way_t victim);
    rsp_t e;
    int   vw;
    @(posedge clk_i);
    idle_strobes();
    rreq_i       <= 1'b1;
    rd_idx_i     <= idx;
    rd_tag_i     <= tag;
    victim_way_i <= victim;
    e  = '0;
    vw = victim[1] ? 1 : 0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag)
      begin
        e.ways[w] = 1'b1;
        e.line    = m_line[idx][w];
      end
    end
    e.hit       = |e.ways;
    e.chk_evict = m_valid[idx][vw];
    e.etag      = m_tag[idx][vw];
    e.eline     = m_line[idx][vw];
    e.edirty    = m_valid[idx][vw] & m_dirty[idx][vw];   // invalid way never dirty
    exp_q.push_back(e);
    rd_cnt++;
  endtask

  task automatic do_fill(input idx_t idx, input tag_t tag, input way_t way,
                         input line_t line, input logic dirty);
    int wi;
    @(posedge clk_i);
    idle_strobes();
    fill_i       <= 1'b1;
    fill_idx_i   <= idx;
    fill_tag_i   <= tag;
    fill_way_i   <= way;
    fill_line_i  <= line;
    fill_dirty_i <= dirty;
    wi = way[1] ? 1 : 0;
    m_valid[idx][wi] = 1'b1;
    m_dirty[idx][wi] = dirty;
    m_tag[idx][wi]   = tag;
    m_line[idx][wi]  = line;
  endtask

  task automatic do_write(input idx_t idx, input way_t way, input woffs_t woffs,
                          input word_be_t be, input word_t data);
    int wi;
    @(posedge clk_i);
    idle_strobes();
    wb_we_i    <= 1'b1;
    wb_idx_i   <= idx;
    wb_way_i   <= way;
    wb_woffs_i <= woffs;
    wb_be_i    <= be;
    wb_data_i  <= data;
    wi = way[1] ? 1 : 0;
    for (int b = 0; b < `CACHE_XLEN / 8; b++)
    begin
      if (be[b])
        m_line[idx][wi][int'(woffs) * `CACHE_XLEN + b * 8 +: 8] = data[b * 8 +: 8];
    end
    m_dirty[idx][wi] = 1'b1;    // even with no byte enabled
  endtask

  task automatic do_inval();
    @(posedge clk_i);
    idle_strobes();
    inval_all_i <= 1'b1;
    for (int s = 0; s < `CACHE_SETS; s++)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
        m_valid[s][w] = 1'b0;
    end
  endtask

  // wait for every read in flight, bounded
  task automatic drain_responses();
    int n;
    idle_cycle();
    n = 0;
    while (exp_q.size() != 0 && n < 10)
    begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout, %0d read responses never arrived", exp_q.size());
      $display("Test FAILED");
      $finish;
    end
  endtask

  task automatic report_test(input string name);
    drain_responses();
    test_cnt++;
    $display("test %0d %s: %0d reads, %0d errors", test_cnt, name, rd_cnt,
             err_cnt - test_err0);
    rd_cnt    = 0;
    test_err0 = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    logic [31:0] r;
    idx_t        ridx;
    way_t        rway;
    rng_state = 32'hd7ae_af5c;
    err_cnt   = 0;
    chk_cnt   = 0;
    test_cnt  = 0;
    rd_cnt    = 0;
    test_err0 = 0;
    for (int s = 0; s < `CACHE_SETS; s++)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    rst_ni       <= 1'b0;
    rreq_i       <= 1'b0;
    rd_idx_i     <= '0;
    rd_tag_i     <= '0;
    victim_way_i <= 2'b01;
    fill_i       <= 1'b0;
    fill_idx_i   <= '0;
    fill_tag_i   <= '0;
    fill_way_i   <= 2'b01;
    fill_line_i  <= '0;
    fill_dirty_i <= 1'b0;
    wb_we_i      <= 1'b0;
    wb_idx_i     <= '0;
    wb_woffs_i   <= '0;
    wb_be_i      <= '0;
    wb_data_i    <= '0;
    wb_way_i     <= 2'b01;
    inval_all_i  <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // every set empty after reset
    for (int s = 0; s < `CACHE_SETS; s++)
      do_read(idx_t'(s), tag_t'(lcg_next()), s[0] ? 2'b10 : 2'b01);
    report_test("reset miss");

    do_fill(4'd3, 26'h2a5_1c3, 2'b01, rand_line(), 1'b1);
    do_read(4'd3, 26'h2a5_1c3, 2'b01);
    do_read(4'd3, 26'h2a5_1c3, 2'b10);
    do_fill(4'd5, 26'h13_0077, 2'b10, rand_line(), 1'b0);
    do_read(4'd5, 26'h13_0077, 2'b10);
    do_read(4'd5, 26'h13_0078, 2'b10);   // tag miss
    report_test("fill then hit");

    do_fill(4'd7, 26'h100, 2'b01, rand_line(), 1'b0);
    do_fill(4'd7, 26'h200, 2'b10, rand_line(), 1'b1);
    do_read(4'd7, 26'h100, 2'b10);
    do_read(4'd7, 26'h200, 2'b01);
    do_read(4'd7, 26'h300, 2'b01);
    report_test("two ways");

    do_fill(4'd9, 26'h3_0009, 2'b10, rand_line(), 1'b0);
    do_read(4'd9, 26'h3_0009, 2'b10);    // still clean
    do_write(4'd9, 2'b10, 2'd2, 4'b0101, 32'hdead_beef);
    do_read(4'd9, 26'h3_0009, 2'b10);
    do_read(4'd9, 26'h3_0009, 2'b01);
    report_test("word write");

    for (int s = 0; s < 4; s++)
    begin
      do_fill(idx_t'(s), tag_t'(s * 2), 2'b01, rand_line(), 1'b1);
      do_fill(idx_t'(s), tag_t'(s * 2 + 1), 2'b10, rand_line(), 1'b0);
    end
    do_inval();
    for (int s = 0; s < 4; s++)
      do_read(idx_t'(s), tag_t'(s * 2), 2'b01);
    do_fill(4'd1, 26'h2, 2'b01, rand_line(), 1'b0);
    do_read(4'd1, 26'h2, 2'b01);
    report_test("invalidate all");

    // mixed traffic, fill tag lsb tracks the way so no double hit
    for (int i = 0; i < 400; i++)
    begin
      r    = lcg_next();
      ridx = idx_t'(r[7:4]);
      rway = r[8] ? 2'b10 : 2'b01;
      case (r[2:0])
        3'd0, 3'd1, 3'd2: do_read(ridx, tag_t'(r[11:9]), rway);
        3'd3: do_fill(ridx, tag_t'({r[10:9], r[8]}), rway, rand_line(), r[12]);
        3'd4:
        begin
          if (m_valid[ridx][r[8]])
            do_write(ridx, rway, woffs_t'(r[14:13]), word_be_t'(r[18:15]), lcg_next());
          else
            idle_cycle();
        end
        default: idle_cycle();
      endcase
    end
    report_test("random traffic");

    $display("tests %0d, responses checked %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
logic/cache_pkg.sv
logic/cache_ram_1rw.sv
logic/cache_access_ctl.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_lookup.sv
logic/cache_mem_top.sv
sim/tb_cache_mem.sv

/* Makefile */
# Verilator build and run of the cache storage core testbench

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_cache_mem -o Vtb_cache_mem
	./obj_dir/Vtb_cache_mem > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
